/* src.f */
verilog/lsq_pkg.sv
verilog/store_queue.sv
verilog/store_forward_match.sv
verilog/load_queue.sv
verilog/lsq.sv
tests/lsq_tb.sv

/* tests/lsq_tb.sv */
module lsq_tb;
	timeunit 1ns;
	timeprecision 1ps;

	logic clock, reset, id_wr_mem0, id_wr_mem1, rs_valid_inst, rs_rd_mem, rs_wr_mem;
	logic rob_retire_wr_mem0, rob_retire_wr_mem1, dcache_avail;
	logic cdb_complete, prf_pr_wr_enable, dcache_rd_mem;
	logic [1:0] rob_retire_num;
	lsq_pkg::inst_t rs_ir;
	lsq_pkg::word_t prf_pra_value, prf_prb_value, prf_pr_value, dcache_addr;
	lsq_pkg::word_t dcache_st_addr0, dcache_st_addr1, dcache_st_value0, dcache_st_value1;
	lsq_pkg::stq_age_t rs_issue_age, rs_disp_age0, rs_disp_age1;
	lsq_pkg::pr_idx_t rs_dest_pr_idx, cdb_prf_pr_idx, dcache_pr_idx;
	lsq_pkg::ar_idx_t rs_dest_ar_idx, cdb_ar_idx, dcache_ar_idx;
	lsq_pkg::avail_t rs_avail, stq_space;

	// Reference store list indexed by age and its wrapping pointers
	lsq_pkg::word_t m_addr [lsq_pkg::STQ_LEN];
	lsq_pkg::word_t m_value [lsq_pkg::STQ_LEN];
	lsq_pkg::stq_age_t m_head, m_tail;
	int checks [6];
	int errors [6];
	string names [6] = '{"reset", "dispatch ages", "store completion",
		"forwarding", "cache path", "retire"};
	bit timed_out;

	lsq u_lsq (.*);

	initial
	begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	task automatic check_value(input int cat, input logic [63:0] got, input logic [63:0] exp,
		input string what);
		checks[cat]++;
		if (got !== exp)
		begin
			errors[cat]++;
			$display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic idle_inputs();
		id_wr_mem0 = 1'b0;
		id_wr_mem1 = 1'b0;
		rs_valid_inst = 1'b0;
		rs_rd_mem = 1'b0;
		rs_wr_mem = 1'b0;
		rs_ir = '0;
		prf_pra_value = '0;
		prf_prb_value = '0;
		rs_issue_age = '0;
		rs_dest_pr_idx = '0;
		rs_dest_ar_idx = '0;
		rob_retire_num = '0;
		rob_retire_wr_mem0 = 1'b0;
		rob_retire_wr_mem1 = 1'b0;
	endtask

	task automatic drive_issue(input logic store, input lsq_pkg::stq_age_t age,
		input lsq_pkg::word_t base, input logic [15:0] disp, input lsq_pkg::word_t data,
		input lsq_pkg::pr_idx_t pr, input lsq_pkg::ar_idx_t ar);
		rs_valid_inst = 1'b1;
		rs_wr_mem = store;
		rs_rd_mem = !store;
		rs_issue_age = age;
		// Upper instruction bits are random noise
		rs_ir = {16'($urandom), disp};
		prf_prb_value = base;
		prf_pra_value = data;
		rs_dest_pr_idx = pr;
		rs_dest_ar_idx = ar;
	endtask

	// Small address pool so that loads often hit several stores
	function automatic lsq_pkg::word_t pool_base();
		return 64'h2000 + lsq_pkg::word_t'($urandom_range(0, 3)) * 8;
	endfunction

	task automatic report_test(input int cat);
		$display("%s: %0d checks, %0d errors", names[cat], checks[cat], errors[cat]);
	endtask

	task automatic run_round();
		lsq_pkg::stq_age_t ages [2];
		lsq_pkg::stq_age_t p;
		lsq_pkg::word_t base, addr, value;
		logic [15:0] disp;
		lsq_pkg::pr_idx_t pr;
		lsq_pkg::ar_idx_t ar;
		logic w0, w1, hit;
		int n_st, used, hold, cat, wait_cnt, off;
		p = m_tail - m_head;
		used = p;
		w0 = (used < lsq_pkg::STQ_LEN) ? 1'($urandom) : 1'b0;
		w1 = (used + w0 < lsq_pkg::STQ_LEN) ? 1'($urandom) : 1'b0;
		id_wr_mem0 = w0;
		id_wr_mem1 = w1;
		p = m_tail + w0;
		#1;
		check_value(1, rs_disp_age0, m_tail, "rs_disp_age0");
		check_value(1, rs_disp_age1, p, "rs_disp_age1");
		// New stores fill the ages from the old tail upward
		ages[0] = m_tail;
		ages[1] = m_tail + 1;
		n_st = w0 + w1;
		@(negedge clock);
		id_wr_mem0 = 1'b0;
		id_wr_mem1 = 1'b0;
		m_tail = m_tail + n_st;
		// A store issued in one cycle completes on the CDB in the next
		for (int k = 0; k < n_st; k++)
		begin
			p = ages[k];
			base = pool_base();
			off = int'($urandom_range(0, 2)) * 8 - 8;
			disp = 16'(off);
			pr = 7'($urandom);
			ar = 5'($urandom);
			m_addr[p[lsq_pkg::STQ_BITS-1:0]] = base + lsq_pkg::word_t'(longint'(off));
			m_value[p[lsq_pkg::STQ_BITS-1:0]] = {$urandom, $urandom};
			drive_issue(1'b1, p, base, disp, m_value[p[lsq_pkg::STQ_BITS-1:0]], pr, ar);
			@(negedge clock);
			idle_inputs();
			check_value(2, {cdb_complete, prf_pr_wr_enable}, 2'b10, "store CDB strobes");
			check_value(2, cdb_prf_pr_idx, pr, "store cdb_prf_pr_idx");
			check_value(2, cdb_ar_idx, ar, "store cdb_ar_idx");
		end
		// Load at the tail age with now and then a far base that no store matches
		base = ($urandom_range(0, 3) == 0) ? 64'h9000_0000 : pool_base();
		off = int'($urandom_range(0, 2)) * 8 - 8;
		disp = 16'(off);
		addr = base + lsq_pkg::word_t'(longint'(off));
		pr = 7'($urandom);
		ar = 5'($urandom);
		hit = 1'b0;
		value = '0;
		p = m_tail - m_head;
		used = p;
		// Walk oldest to youngest so the last match wins
		for (int j = 0; j < used; j++)
		begin
			p = m_head + j;
			if (m_addr[p[lsq_pkg::STQ_BITS-1:0]] == addr)
			begin
				hit = 1'b1;
				value = m_value[p[lsq_pkg::STQ_BITS-1:0]];
			end
		end
		cat = hit ? 3 : 4;
		hold = (!hit && $urandom_range(0, 1)) ? $urandom_range(2, 5) : 0;
		check_value(cat, rs_avail, 2, "rs_avail before load");
		drive_issue(1'b0, m_tail, base, disp, '0, pr, ar);
		dcache_avail = (hold == 0);
		@(negedge clock);
		idle_inputs();
		for (int h = 0; h < hold; h++)
		begin
			@(negedge clock);
			check_value(4, dcache_rd_mem, 0, "dcache_rd_mem while cache busy");
		end
		dcache_avail = 1'b1;
		wait_cnt = 0;
		while (!cdb_complete && !dcache_rd_mem && wait_cnt < 20)
		begin
			@(negedge clock);
			wait_cnt++;
		end
		if (!cdb_complete && !dcache_rd_mem)
		begin
			$display("Timeout: load with tag %0d never left the load queue", pr);
			timed_out = 1'b1;
			return;
		end
		check_value(cat, {cdb_complete, prf_pr_wr_enable, dcache_rd_mem},
			hit ? 3'b110 : 3'b001, "load strobes");
		check_value(cat, hit ? cdb_prf_pr_idx : dcache_pr_idx, pr, "load pr tag");
		check_value(cat, hit ? cdb_ar_idx : dcache_ar_idx, ar, "load ar tag");
		check_value(cat, hit ? prf_pr_value : dcache_addr, hit ? value : addr, "load data");
		// Only retiring slots flagged as stores free an entry
		rob_retire_num = 2'($urandom_range(0, 2));
		rob_retire_wr_mem0 = 1'($urandom);
		rob_retire_wr_mem1 = 1'($urandom);
		n_st = int'(rob_retire_num != 0 && rob_retire_wr_mem0)
			+ int'(rob_retire_num == 2 && rob_retire_wr_mem1);
		if (n_st > used)
		begin
			rob_retire_wr_mem0 = 1'b0;
			rob_retire_wr_mem1 = 1'b0;
			n_st = 0;
		end
		@(negedge clock);
		idle_inputs();
		m_head = m_head + n_st;
		p = m_tail - m_head;
		used = p;
		check_value(5, stq_space, (lsq_pkg::STQ_LEN - used > 2) ? 2 : lsq_pkg::STQ_LEN - used,
			"stq_space");
		p = m_head;
		if (used >= 1)
		begin
			check_value(5, dcache_st_addr0, m_addr[p[lsq_pkg::STQ_BITS-1:0]], "dcache_st_addr0");
			check_value(5, dcache_st_value0, m_value[p[lsq_pkg::STQ_BITS-1:0]], "dcache_st_value0");
		end
		p = m_head + 1;
		if (used >= 2)
		begin
			check_value(5, dcache_st_addr1, m_addr[p[lsq_pkg::STQ_BITS-1:0]], "dcache_st_addr1");
			check_value(5, dcache_st_value1, m_value[p[lsq_pkg::STQ_BITS-1:0]], "dcache_st_value1");
		end
	endtask

	initial
	begin
		int total_checks;
		int total_errors;
		void'($urandom(53979));
		reset = 1'b1;
		dcache_avail = 1'b1;
		idle_inputs();
		m_head = '0;
		m_tail = '0;
		repeat (2) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		check_value(0, rs_avail, 2, "rs_avail after reset");
		check_value(0, stq_space, 2, "stq_space after reset");
		repeat (3)
		begin
			@(negedge clock);
			check_value(0, {cdb_complete, prf_pr_wr_enable, dcache_rd_mem}, 0, "idle strobes");
		end
		report_test(0);
		for (int r = 0; r < 80 && !timed_out; r++)
			run_round();
		total_checks = checks[0];
		total_errors = errors[0];
		for (int c = 1; c < 6; c++)
		begin
			report_test(c);
			total_checks += checks[c];
			total_errors += errors[c];
		end
		$display("Tests: 6, checks: %0d, errors: %0d", total_checks, total_errors);
		if (total_errors == 0 && !timed_out)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

/* verilog/lsq.sv */
module lsq #(
	parameter int STQ_LEN = lsq_pkg::STQ_LEN,
	parameter int LDQ_LEN = lsq_pkg::LDQ_LEN
) (
	input  logic clock,
	input  logic reset,
	// Dispatch
	input  logic id_wr_mem0,
	input  logic id_wr_mem1,
	output lsq_pkg::stq_age_t rs_disp_age0,
	output lsq_pkg::stq_age_t rs_disp_age1,
	// Issue
	input  logic rs_valid_inst,
	input  logic rs_rd_mem,
	input  logic rs_wr_mem,
	input  lsq_pkg::inst_t rs_ir,
	input  lsq_pkg::word_t prf_pra_value,
	input  lsq_pkg::word_t prf_prb_value,
	input  lsq_pkg::stq_age_t rs_issue_age,
	input  lsq_pkg::pr_idx_t rs_dest_pr_idx,
	input  lsq_pkg::ar_idx_t rs_dest_ar_idx,
	output lsq_pkg::avail_t rs_avail,
	output lsq_pkg::avail_t stq_space,
	// Retire
	input  logic [1:0] rob_retire_num,
	input  logic rob_retire_wr_mem0,
	input  logic rob_retire_wr_mem1,
	// CDB
	output logic cdb_complete,
	output lsq_pkg::pr_idx_t cdb_prf_pr_idx,
	output lsq_pkg::ar_idx_t cdb_ar_idx,
	output logic prf_pr_wr_enable,
	output lsq_pkg::word_t prf_pr_value,
	// Data cache
	input  logic dcache_avail,
	output logic dcache_rd_mem,
	output lsq_pkg::word_t dcache_addr,
	output lsq_pkg::pr_idx_t dcache_pr_idx,
	output lsq_pkg::ar_idx_t dcache_ar_idx,
	output lsq_pkg::word_t dcache_st_addr0,
	output lsq_pkg::word_t dcache_st_addr1,
	output lsq_pkg::word_t dcache_st_value0,
	output lsq_pkg::word_t dcache_st_value1
);

	// Store queue state scanned by the load queue
	logic [STQ_LEN-1:0] st_ready;
	lsq_pkg::word_t st_addr [STQ_LEN];
	lsq_pkg::word_t st_value [STQ_LEN];
	lsq_pkg::stq_age_t st_head;

	// Store completion that takes the CDB this cycle
	logic st_issue;
	lsq_pkg::pr_idx_t st_issue_pr_idx;
	lsq_pkg::ar_idx_t st_issue_ar_idx;

	store_queue #(
		.STQ_LEN(STQ_LEN)
	) u_store_queue (.*);

	load_queue #(
		.STQ_LEN(STQ_LEN),
		.LDQ_LEN(LDQ_LEN)
	) u_load_queue (.*);

endmodule

/* verilog/load_queue.sv */
module load_queue #(
	parameter int STQ_LEN = lsq_pkg::STQ_LEN,
	parameter int LDQ_LEN = lsq_pkg::LDQ_LEN
) (
	input  logic clock,
	input  logic reset,
	// Issue
	input  logic rs_valid_inst,
	input  logic rs_rd_mem,
	input  lsq_pkg::inst_t rs_ir,
	input  lsq_pkg::word_t prf_prb_value,
	input  lsq_pkg::stq_age_t rs_issue_age,
	input  lsq_pkg::pr_idx_t rs_dest_pr_idx,
	input  lsq_pkg::ar_idx_t rs_dest_ar_idx,
	output lsq_pkg::avail_t rs_avail,
	// Store queue state
	input  logic [STQ_LEN-1:0] st_ready,
	input  lsq_pkg::word_t st_addr [STQ_LEN],
	input  lsq_pkg::word_t st_value [STQ_LEN],
	input  lsq_pkg::stq_age_t st_head,
	input  logic st_issue,
	input  lsq_pkg::pr_idx_t st_issue_pr_idx,
	input  lsq_pkg::ar_idx_t st_issue_ar_idx,
	// CDB
	output logic cdb_complete,
	output lsq_pkg::pr_idx_t cdb_prf_pr_idx,
	output lsq_pkg::ar_idx_t cdb_ar_idx,
	output logic prf_pr_wr_enable,
	output lsq_pkg::word_t prf_pr_value,
	// Cache read
	input  logic dcache_avail,
	output logic dcache_rd_mem,
	output lsq_pkg::word_t dcache_addr,
	output lsq_pkg::pr_idx_t dcache_pr_idx,
	output lsq_pkg::ar_idx_t dcache_ar_idx
);

	logic [LDQ_LEN-1:0] ld_valid;
	lsq_pkg::word_t ld_addr [LDQ_LEN];
	lsq_pkg::stq_age_t ld_age [LDQ_LEN];
	lsq_pkg::pr_idx_t ld_pr [LDQ_LEN];
	lsq_pkg::ar_idx_t ld_ar [LDQ_LEN];

	logic [LDQ_LEN-1:0] fwd_ready;
	logic [LDQ_LEN-1:0] fwd_hit;
	lsq_pkg::word_t fwd_value [LDQ_LEN];

	logic [LDQ_LEN-1:0] can_leave;
	logic [lsq_pkg::LDQ_BITS-1:0] alloc_idx;
	logic [lsq_pkg::LDQ_BITS-1:0] pick_idx;
	logic ld_in;
	logic pick_any;
	logic fwd_go;
	logic cache_go;
	int free_cnt;

	// Index of the lowest set bit, zero when none is set
	function automatic logic [lsq_pkg::LDQ_BITS-1:0] lowest_set(input logic [LDQ_LEN-1:0] vec);
		logic [lsq_pkg::LDQ_BITS-1:0] idx;
		idx = '0;
		for (int k = LDQ_LEN - 1; k >= 0; k--)
		begin
			if (vec[k])
				idx = k[lsq_pkg::LDQ_BITS-1:0];
		end
		return idx;
	endfunction

	always_comb
	begin
		free_cnt = 0;
		for (int k = 0; k < LDQ_LEN; k++)
			free_cnt = free_cnt + int'(!ld_valid[k]);
	end

	assign rs_avail = (free_cnt >= 2) ? 2'd2 : lsq_pkg::avail_t'(free_cnt);

	assign ld_in = rs_valid_inst & rs_rd_mem & (|(~ld_valid));
	assign alloc_idx = lowest_set(~ld_valid);

	for (genvar i = 0; i < LDQ_LEN; i++)
	begin : g_match
		store_forward_match #(
			.STQ_LEN(STQ_LEN)
		) u_match (
			.ld_addr(ld_addr[i]),
			.ld_age(ld_age[i]),
			.st_head(st_head),
			.st_ready(st_ready),
			.st_addr(st_addr),
			.st_value(st_value),
			.fwd_ready(fwd_ready[i]),
			.fwd_hit(fwd_hit[i]),
			.fwd_value(fwd_value[i])
		);

		// Forwarding waits while a store owns the CDB, cache loads wait on the cache
		assign can_leave[i] = ld_valid[i] & fwd_ready[i] & (fwd_hit[i] ? !st_issue : dcache_avail);
	end

	assign pick_any = |can_leave;
	assign pick_idx = lowest_set(can_leave);
	assign fwd_go = pick_any & fwd_hit[pick_idx];
	assign cache_go = pick_any & !fwd_hit[pick_idx];

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			ld_valid <= '0;
			cdb_complete <= 1'b0;
			prf_pr_wr_enable <= 1'b0;
			dcache_rd_mem <= 1'b0;
		end
		else
		begin
			cdb_complete <= st_issue | fwd_go;
			prf_pr_wr_enable <= fwd_go;
			dcache_rd_mem <= cache_go;
			if (pick_any)
				ld_valid[pick_idx] <= 1'b0;
			// The allocated slot is free, so it never equals the leaving slot
			if (ld_in)
				ld_valid[alloc_idx] <= 1'b1;
		end
	end

	always_ff @(posedge clock)
	begin
		if (ld_in)
		begin
			ld_addr[alloc_idx] <= prf_prb_value + {{48{rs_ir[15]}}, rs_ir[15:0]};
			ld_age[alloc_idx] <= rs_issue_age;
			ld_pr[alloc_idx] <= rs_dest_pr_idx;
			ld_ar[alloc_idx] <= rs_dest_ar_idx;
		end
		if (st_issue)
		begin
			cdb_prf_pr_idx <= st_issue_pr_idx;
			cdb_ar_idx <= st_issue_ar_idx;
		end
		else if (fwd_go)
		begin
			cdb_prf_pr_idx <= ld_pr[pick_idx];
			cdb_ar_idx <= ld_ar[pick_idx];
			prf_pr_value <= fwd_value[pick_idx];
		end
		if (cache_go)
		begin
			dcache_addr <= ld_addr[pick_idx];
			dcache_pr_idx <= ld_pr[pick_idx];
			dcache_ar_idx <= ld_ar[pick_idx];
		end
	end

endmodule

/* verilog/store_forward_match.sv */
module store_forward_match #(
	parameter int STQ_LEN = lsq_pkg::STQ_LEN
) (
	input  lsq_pkg::word_t ld_addr,
	input  lsq_pkg::stq_age_t ld_age,
	input  lsq_pkg::stq_age_t st_head,
	input  logic [STQ_LEN-1:0] st_ready,
	input  lsq_pkg::word_t st_addr [STQ_LEN],
	input  lsq_pkg::word_t st_value [STQ_LEN],
	output logic fwd_ready,
	output logic fwd_hit,
	output lsq_pkg::word_t fwd_value
);

	lsq_pkg::stq_age_t older_cnt;
	lsq_pkg::stq_age_t pos;

	// Stores from the head up to the load's age are older than the load
	assign older_cnt = ld_age - st_head;

	// Walk from oldest to youngest, so the last match found is the youngest
	always_comb
	begin
		fwd_ready = 1'b1;
		fwd_hit = 1'b0;
		fwd_value = '0;
		pos = st_head;
		for (int j = 0; j < STQ_LEN; j++)
		begin
			pos = st_head + lsq_pkg::stq_age_t'(j);
			if (lsq_pkg::stq_age_t'(j) < older_cnt)
			begin
				if (!st_ready[pos[lsq_pkg::STQ_BITS-1:0]])
				begin
					fwd_ready = 1'b0;
				end
				else if (st_addr[pos[lsq_pkg::STQ_BITS-1:0]] == ld_addr)
				begin
					fwd_hit = 1'b1;
					fwd_value = st_value[pos[lsq_pkg::STQ_BITS-1:0]];
				end
			end
		end
	end

endmodule

/* verilog/store_queue.sv */
module store_queue #(
	parameter int STQ_LEN = lsq_pkg::STQ_LEN
) (
	input  logic clock,
	input  logic reset,
	// Dispatch
	input  logic id_wr_mem0,
	input  logic id_wr_mem1,
	output lsq_pkg::stq_age_t rs_disp_age0,
	output lsq_pkg::stq_age_t rs_disp_age1,
	output lsq_pkg::avail_t stq_space,
	// Issue
	input  logic rs_valid_inst,
	input  logic rs_wr_mem,
	input  lsq_pkg::inst_t rs_ir,
	input  lsq_pkg::word_t prf_pra_value,
	input  lsq_pkg::word_t prf_prb_value,
	input  lsq_pkg::stq_age_t rs_issue_age,
	input  lsq_pkg::pr_idx_t rs_dest_pr_idx,
	input  lsq_pkg::ar_idx_t rs_dest_ar_idx,
	// Retire
	input  logic [1:0] rob_retire_num,
	input  logic rob_retire_wr_mem0,
	input  logic rob_retire_wr_mem1,
	// State seen by the load queue
	output logic [STQ_LEN-1:0] st_ready,
	output lsq_pkg::word_t st_addr [STQ_LEN],
	output lsq_pkg::word_t st_value [STQ_LEN],
	output lsq_pkg::stq_age_t st_head,
	output logic st_issue,
	output lsq_pkg::pr_idx_t st_issue_pr_idx,
	output lsq_pkg::ar_idx_t st_issue_ar_idx,
	// Head entries for the cache
	output lsq_pkg::word_t dcache_st_addr0,
	output lsq_pkg::word_t dcache_st_addr1,
	output lsq_pkg::word_t dcache_st_value0,
	output lsq_pkg::word_t dcache_st_value1
);

	lsq_pkg::stq_age_t tail;
	lsq_pkg::stq_age_t used_cnt;
	lsq_pkg::stq_age_t free_cnt;
	lsq_pkg::stq_age_t disp_cnt;
	lsq_pkg::stq_age_t retire_cnt;
	logic [lsq_pkg::STQ_BITS-1:0] head_idx;
	logic [lsq_pkg::STQ_BITS-1:0] head_idx1;
	logic [lsq_pkg::STQ_BITS-1:0] issue_idx;
	lsq_pkg::word_t issue_addr;

	// Dispatch ages, slot 1 sits behind slot 0 when slot 0 is a store
	assign rs_disp_age0 = tail;
	assign rs_disp_age1 = id_wr_mem0 ? tail + 1'b1 : tail;

	// Wrap bit makes tail minus head the exact occupancy
	assign used_cnt = tail - st_head;
	assign free_cnt = lsq_pkg::stq_age_t'(STQ_LEN) - used_cnt;
	assign stq_space = (free_cnt >= 2) ? 2'd2 : free_cnt[1:0];

	assign disp_cnt = lsq_pkg::stq_age_t'(id_wr_mem0) + lsq_pkg::stq_age_t'(id_wr_mem1);

	// Only retiring slots that are stores free an entry
	always_comb
	begin
		retire_cnt = '0;
		if (rob_retire_num != 2'd0 && rob_retire_wr_mem0)
			retire_cnt = retire_cnt + 1'b1;
		if (rob_retire_num == 2'd2 && rob_retire_wr_mem1)
			retire_cnt = retire_cnt + 1'b1;
	end

	assign st_issue = rs_valid_inst & rs_wr_mem;
	assign st_issue_pr_idx = rs_dest_pr_idx;
	assign st_issue_ar_idx = rs_dest_ar_idx;
	assign issue_idx = rs_issue_age[lsq_pkg::STQ_BITS-1:0];
	assign issue_addr = prf_prb_value + {{48{rs_ir[15]}}, rs_ir[15:0]};

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			st_head <= '0;
			tail <= '0;
			st_ready <= '0;
		end
		else
		begin
			st_head <= st_head + retire_cnt;
			tail <= tail + disp_cnt;
			if (id_wr_mem0)
				st_ready[tail[lsq_pkg::STQ_BITS-1:0]] <= 1'b0;
			if (id_wr_mem1)
				st_ready[rs_disp_age1[lsq_pkg::STQ_BITS-1:0]] <= 1'b0;
			// An issuing store is already allocated, so it never collides with dispatch
			if (st_issue)
				st_ready[issue_idx] <= 1'b1;
		end
	end

	always_ff @(posedge clock)
	begin
		if (st_issue)
		begin
			st_addr[issue_idx] <= issue_addr;
			st_value[issue_idx] <= prf_pra_value;
		end
	end

	assign head_idx = st_head[lsq_pkg::STQ_BITS-1:0];
	assign head_idx1 = head_idx + 1'b1;

	assign dcache_st_addr0 = st_addr[head_idx];
	assign dcache_st_addr1 = st_addr[head_idx1];
	assign dcache_st_value0 = st_value[head_idx];
	assign dcache_st_value1 = st_value[head_idx1];

endmodule

/* verilog/lsq_pkg.sv */
package lsq_pkg;

	// Store queue size and index width
	parameter int STQ_LEN = 8;
	parameter int STQ_BITS = 3;

	// Load queue size and slot index width
	parameter int LDQ_LEN = 4;
	parameter int LDQ_BITS = 2;

	// 64-bit data or address word
	typedef logic [63:0] word_t;

	// Instruction word, low 16 bits hold the signed displacement
	typedef logic [31:0] inst_t;

	// Register tags
	typedef logic [6:0] pr_idx_t;
	typedef logic [4:0] ar_idx_t;

	// Store queue pointer, index plus one wrap bit
	typedef logic [STQ_BITS:0] stq_age_t;

	// Saturating free count of 0, 1 or 2
	typedef logic [1:0] avail_t;

endpackage
